/* Makefile */
# Verilator build and run of the fetch stage testbench
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard logic/*.sv sim/*.sv)
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail, not the exit status of the binary
run: compile
	./$(EXE) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
logic/fetch_pkg.sv
logic/thread_queue.sv
logic/fetch_arbiter.sv
logic/dispatch_select.sv
logic/fetch_top.sv
sim/fetch_checker.sv
sim/tb_top.sv

/* logic/dispatch_select.sv */
`timescale 1ns/1ns
// Dispatch selector
// Takes turns between the threads, skipping empty or flushing ones, and
// offers up to DP_NUM head entries of the chosen queue
module dispatch_select #(
    parameter int THREAD_NUM = 2,
    parameter int FIQ_DEPTH  = 8
) (
    input  logic                                                 clk_i,
    input  logic                                                 rst_i,
    input  fetch_pkg::queue_status_t [THREAD_NUM-1:0]            status_i,
    input  fetch_pkg::fiq_entry_t [THREAD_NUM-1:0][FIQ_DEPTH-1:0] entries_i,
    input  logic [THREAD_NUM-1:0][$clog2(FIQ_DEPTH)-1:0]         head_i,
    input  logic [fetch_pkg::DP_CNT_W-1:0]                       dp_take_i,
    output logic [THREAD_NUM-1:0][fetch_pkg::DP_CNT_W-1:0]       pop_cnt_o,
    output fetch_pkg::dp_bundle_t                                dp_o
);
    localparam int TID_W  = $clog2(THREAD_NUM);
    localparam int IDX_W  = $clog2(FIQ_DEPTH);
    localparam int FW     = fetch_pkg::FREE_CNT_W;
    localparam int DPW    = fetch_pkg::DP_CNT_W;
    localparam int DP_N   = fetch_pkg::DP_NUM;

    logic [TID_W-1:0]              cnt_q;       // Thread whose turn it is
    logic [TID_W-1:0]              sel;         // Thread offered this cycle
    logic                          found;
    logic [FW-1:0]                 occ;
    logic [DP_N-1:0][IDX_W-1:0]    rd_idx;

    // ====================================================================
    // Thread choice
    // ====================================================================
    // Scan from the counter, the nearest ready thread wins
    always_comb
    begin : pick
        logic [TID_W-1:0] cand;
        sel   = cnt_q;
        found = 1'b0;
        for (int i = THREAD_NUM - 1; i >= 0; i--)
        begin
            cand = cnt_q + TID_W'(i);
            if (!status_i[cand].empty && !status_i[cand].flushing)
            begin
                sel   = cand;
                found = 1'b1;
            end
        end
    end

    assign occ = FW'(FIQ_DEPTH) - status_i[sel].free_cnt;

    // ====================================================================
    // Bundle
    // ====================================================================
    always_comb
    begin
        if (!found)
            dp_o.avail_num = '0;
        else if (occ >= FW'(DP_N))
            dp_o.avail_num = DPW'(DP_N);            // Ceiling on the offer
        else
            dp_o.avail_num = DPW'(occ);
        dp_o.thread = fetch_pkg::thread_t'(sel);
        for (int n = 0; n < DP_N; n++)
        begin
            rd_idx[n]    = head_i[sel] + IDX_W'(n);   // Wraps around the buffer
            dp_o.inst[n] = entries_i[sel][rd_idx[n]].inst;
            dp_o.pc[n]   = entries_i[sel][rd_idx[n]].pc;
        end
    end

    // Only the offered thread pops
    always_comb
    begin
        pop_cnt_o = '0;
        if (found)
            pop_cnt_o[sel] = dp_take_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            cnt_q <= '0;
        else if (found)
            cnt_q <= sel + TID_W'(1);               // Next turn goes past it
    end

    // Dispatcher stays within the offer
    a_take_le_avail: assert property (@(posedge clk_i) disable iff (rst_i)
        dp_take_i <= dp_o.avail_num);

endmodule

/* logic/fetch_arbiter.sv */
`timescale 1ns/1ns
// Round-robin fetch arbiter
// Points at one thread per cycle and issues its block-aligned cache
// request when that thread may fetch
module fetch_arbiter #(
    parameter int THREAD_NUM = 2
) (
    input  logic                                     clk_i,
    input  logic                                     rst_i,
    input  logic [THREAD_NUM-1:0]                    thread_en_i,
    input  logic [THREAD_NUM-1:0]                    br_mis_valid_i,
    input  fetch_pkg::queue_status_t [THREAD_NUM-1:0] status_i,
    output logic [THREAD_NUM-1:0]                    issue_o,
    output fetch_pkg::fetch_req_t                    ic_req_o
);
    localparam int TID_W = $clog2(THREAD_NUM);
    localparam int XLEN  = fetch_pkg::XLEN;
    localparam int OFF_W = fetch_pkg::OFFSET_W;

    logic [TID_W-1:0]          ptr_q;       // Thread allowed to fetch
    logic                      run_q;       // Holds off the first cycle out of reset
    fetch_pkg::queue_status_t  cur;
    logic                      can_issue;

    assign cur = status_i[ptr_q];

    // Enabled, not flushing, nothing outstanding and room for one
    assign can_issue = run_q && thread_en_i[ptr_q] && !br_mis_valid_i[ptr_q] &&
                       !cur.pending && (cur.free_cnt != '0);

    always_comb
    begin
        issue_o        = '0;
        issue_o[ptr_q] = can_issue;                 // Sets pending at the edge
    end

    assign ic_req_o.valid  = can_issue;
    assign ic_req_o.thread = fetch_pkg::thread_t'(ptr_q);
    assign ic_req_o.addr   = {cur.pc[XLEN-1:OFF_W], {OFF_W{1'b0}}};

    // Pointer moves on every cycle whether or not a request issued
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            ptr_q <= '0;
            run_q <= 1'b0;
        end
        else
        begin
            ptr_q <= ptr_q + TID_W'(1);
            run_q <= 1'b1;
        end
    end

    // The issued thread shows its request outstanding in the next cycle
    a_issue_pending: assert property (@(posedge clk_i) disable iff (rst_i)
        $past(ic_req_o.valid) |-> status_i[$past(ptr_q)].pending);

endmodule

/* logic/fetch_pkg.sv */
// Fetch stage shared definitions
// Block geometry, cache bus structs, queue entry, status and dispatch bundle
package fetch_pkg;

    // ====================================================================
    // Constants
    // ====================================================================
    parameter int XLEN        = 32;     // Address and instruction width
    parameter int BLOCK_INSTS = 4;      // Instructions per cache block
    parameter int BLOCK_BYTES = 16;
    parameter int OFFSET_W    = 4;      // Byte offset within a block
    parameter int DP_NUM      = 2;      // Max instructions offered per cycle
    parameter int DP_CNT_W    = 2;      // Holds 0..DP_NUM
    parameter int INS_CNT_W   = 3;      // Holds 0..BLOCK_INSTS
    parameter int THREAD_W    = 1;      // Thread field on the buses, two threads
    parameter int FREE_CNT_W  = 5;      // Free entry count, queues up to 16 deep

    typedef logic [THREAD_W-1:0] thread_t;

    // ====================================================================
    // Cache interface
    // ====================================================================
    // One block, seen as the bus word or as instruction slots
    typedef union packed {
        logic [BLOCK_BYTES*8-1:0]         raw_word;
        logic [BLOCK_INSTS-1:0][XLEN-1:0] slot;     // Slot 0 at lowest address
    } cache_block_t;

    typedef struct packed {
        logic            valid;     // Single-cycle strobe
        thread_t         thread;
        logic [XLEN-1:0] addr;      // Block aligned
    } fetch_req_t;

    typedef struct packed {
        logic            valid;
        thread_t         thread;
        logic [XLEN-1:0] addr;      // Block address that was requested
        cache_block_t    data;
    } fetch_rsp_t;

    // ====================================================================
    // Queue and dispatch
    // ====================================================================
    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
    } fiq_entry_t;

    typedef struct packed {
        logic                  empty;
        logic                  flushing;    // Mispredict strobe this cycle
        logic                  pending;     // Request outstanding
        logic [FREE_CNT_W-1:0] free_cnt;
        logic [XLEN-1:0]       pc;
    } queue_status_t;

    typedef struct packed {
        logic [DP_CNT_W-1:0]          avail_num;
        thread_t                      thread;
        logic [DP_NUM-1:0][XLEN-1:0]  inst;
        logic [DP_NUM-1:0][XLEN-1:0]  pc;
    } dp_bundle_t;

endpackage

/* logic/fetch_top.sv */
`timescale 1ns/1ns
// Instruction fetch stage top
// Per-thread queues beside the fetch arbiter, merged by the dispatch selector
module fetch_top #(
    parameter int THREAD_NUM = 2,       // Power of two
    parameter int FIQ_DEPTH  = 8
) (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    input  logic [THREAD_NUM-1:0]                        thread_en_i,
    input  logic [THREAD_NUM-1:0][fetch_pkg::XLEN-1:0]   rst_pc_i,
    input  logic [THREAD_NUM-1:0]                        br_mis_valid_i,
    input  logic [THREAD_NUM-1:0][fetch_pkg::XLEN-1:0]   br_mis_target_i,
    input  fetch_pkg::fetch_rsp_t                        ic_rsp_i,
    input  logic [fetch_pkg::DP_CNT_W-1:0]               dp_take_i,
    output fetch_pkg::fetch_req_t                        ic_req_o,
    output fetch_pkg::dp_bundle_t                        dp_o
);
    localparam int IDX_W = $clog2(FIQ_DEPTH);

    // ====================================================================
    // Internal wiring
    // ====================================================================
    fetch_pkg::queue_status_t [THREAD_NUM-1:0]                q_status;
    fetch_pkg::fiq_entry_t [THREAD_NUM-1:0][FIQ_DEPTH-1:0]    q_entries;
    logic [THREAD_NUM-1:0][IDX_W-1:0]                         q_head;
    logic [THREAD_NUM-1:0]                                    issue;      // Arbiter to queues
    logic [THREAD_NUM-1:0][fetch_pkg::DP_CNT_W-1:0]           pop_cnt;    // Selector to queues

    for (genvar t = 0; t < THREAD_NUM; t++)
    begin : g_thread
        thread_queue #(
            .THREAD_NUM (THREAD_NUM),
            .FIQ_DEPTH  (FIQ_DEPTH),
            .THREAD_ID  (t)
        ) u_queue (
            .clk_i           (clk_i),
            .rst_i           (rst_i),
            .rst_pc_i        (rst_pc_i[t]),
            .br_mis_valid_i  (br_mis_valid_i[t]),
            .br_mis_target_i (br_mis_target_i[t]),
            .issue_i         (issue[t]),
            .ic_rsp_i        (ic_rsp_i),             // Each queue filters by thread
            .pop_cnt_i       (pop_cnt[t]),
            .status_o        (q_status[t]),
            .entries_o       (q_entries[t]),
            .head_o          (q_head[t])
        );
    end

    fetch_arbiter #(
        .THREAD_NUM (THREAD_NUM)
    ) u_arb (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .thread_en_i    (thread_en_i),
        .br_mis_valid_i (br_mis_valid_i),
        .status_i       (q_status),
        .issue_o        (issue),
        .ic_req_o       (ic_req_o)
    );

    dispatch_select #(
        .THREAD_NUM (THREAD_NUM),
        .FIQ_DEPTH  (FIQ_DEPTH)
    ) u_disp (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .status_i  (q_status),
        .entries_i (q_entries),
        .head_i    (q_head),
        .dp_take_i (dp_take_i),
        .pop_cnt_o (pop_cnt),
        .dp_o      (dp_o)
    );

endmodule

/* logic/thread_queue.sv */
`timescale 1ns/1ns
// Per-thread fetch context
// PC, pending request flag and a circular instruction queue that is
// filled from cache blocks and drained by dispatch
module thread_queue #(
    parameter int THREAD_NUM = 2,
    parameter int FIQ_DEPTH  = 8,       // Power of two, at least BLOCK_INSTS
    parameter int THREAD_ID  = 0
) (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic [fetch_pkg::XLEN-1:0]            rst_pc_i,
    input  logic                                  br_mis_valid_i,
    input  logic [fetch_pkg::XLEN-1:0]            br_mis_target_i,
    input  logic                                  issue_i,
    input  fetch_pkg::fetch_rsp_t                 ic_rsp_i,
    input  logic [fetch_pkg::DP_CNT_W-1:0]        pop_cnt_i,
    output fetch_pkg::queue_status_t              status_o,
    output fetch_pkg::fiq_entry_t [FIQ_DEPTH-1:0] entries_o,
    output logic [$clog2(FIQ_DEPTH)-1:0]          head_o
);
    localparam int XLEN   = fetch_pkg::XLEN;
    localparam int OFF_W  = fetch_pkg::OFFSET_W;
    localparam int BLK_N  = fetch_pkg::BLOCK_INSTS;
    localparam int ICW    = fetch_pkg::INS_CNT_W;
    localparam int IDX_W  = $clog2(FIQ_DEPTH);
    localparam int PTR_W  = IDX_W + 1;              // Extra bit tells full from empty
    localparam int TID_W  = $clog2(THREAD_NUM);
    localparam int SLOT_W = $clog2(BLK_N);

    // ====================================================================
    // State
    // ====================================================================
    logic [XLEN-1:0]                        pc_q;       // Next PC to fetch
    logic [PTR_W-1:0]                       head_q;
    logic [PTR_W-1:0]                       tail_q;
    logic                                   pending_q;
    fetch_pkg::fiq_entry_t [FIQ_DEPTH-1:0]  buf_q;

    logic [PTR_W-1:0]                       occ;        // Entries held
    logic [PTR_W-1:0]                       free;
    logic [XLEN-1:0]                        blk_addr;
    logic [SLOT_W-1:0]                      slot_off;   // PC slot within the block
    logic [ICW-1:0]                         to_end;     // Slots left up to block end
    logic [ICW-1:0]                         ins_cnt;
    logic [TID_W-1:0]                       rsp_tid;
    logic                                   rsp_hit;
    logic [BLK_N-1:0][IDX_W-1:0]            wr_idx;
    logic [BLK_N-1:0][SLOT_W-1:0]           wr_slot;

    // ====================================================================
    // Insert count
    // ====================================================================
    assign occ      = tail_q - head_q;
    assign free     = PTR_W'(FIQ_DEPTH) - occ;
    assign blk_addr = {pc_q[XLEN-1:OFF_W], {OFF_W{1'b0}}};
    assign slot_off = pc_q[2 +: SLOT_W];            // Drop the byte bits
    assign to_end   = ICW'(BLK_N) - ICW'(slot_off);
    assign rsp_tid  = TID_W'(ic_rsp_i.thread);

    // Ours, expected and still for the current PC, else stale
    assign rsp_hit = ic_rsp_i.valid && (rsp_tid == TID_W'(THREAD_ID)) &&
                     pending_q && (ic_rsp_i.addr == blk_addr);

    always_comb
    begin
        if (!rsp_hit)
            ins_cnt = '0;
        else if (PTR_W'(to_end) > free)
            ins_cnt = ICW'(free);                   // Capped by free space
        else
            ins_cnt = to_end;
    end

    // Slot j of the insert lands at tail + j, read from offset + j
    always_comb
    begin
        for (int j = 0; j < BLK_N; j++)
        begin
            wr_idx[j]  = tail_q[IDX_W-1:0] + IDX_W'(j);
            wr_slot[j] = slot_off + SLOT_W'(j);
        end
    end

    // ====================================================================
    // Control registers
    // ====================================================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            pc_q      <= rst_pc_i;
            head_q    <= '0;
            tail_q    <= '0;
            pending_q <= 1'b0;
        end
        else if (br_mis_valid_i)                    // Flush wins over all else
        begin
            pc_q      <= br_mis_target_i;
            head_q    <= '0;
            tail_q    <= '0;
            pending_q <= 1'b0;
        end
        else
        begin
            pc_q   <= pc_q + (XLEN'(ins_cnt) << 2);
            head_q <= head_q + PTR_W'(pop_cnt_i);
            tail_q <= tail_q + PTR_W'(ins_cnt);
            if (issue_i)
                pending_q <= 1'b1;
            else if (rsp_hit)
                pending_q <= 1'b0;                  // Stale responses keep it set
        end
    end

    // Queue storage, each entry written with its own PC
    always_ff @(posedge clk_i)
    begin
        for (int j = 0; j < BLK_N; j++)
        begin
            if (j < ins_cnt)
            begin
                buf_q[wr_idx[j]].inst <= ic_rsp_i.data.slot[wr_slot[j]];
                buf_q[wr_idx[j]].pc   <= pc_q + XLEN'(4 * j);
            end
        end
    end

    // ====================================================================
    // Outputs
    // ====================================================================
    assign status_o.empty    = (occ == '0);
    assign status_o.flushing = br_mis_valid_i;
    assign status_o.pending  = pending_q;
    assign status_o.free_cnt = fetch_pkg::FREE_CNT_W'(free);
    assign status_o.pc       = pc_q;
    assign entries_o         = buf_q;
    assign head_o            = head_q[IDX_W-1:0];

    // Dispatch never takes more than this queue holds
    a_pop_le_occ: assert property (@(posedge clk_i) disable iff (rst_i)
        PTR_W'(pop_cnt_i) <= occ);

    // Inserts and pops keep the pointers within one lap
    a_occ_le_depth: assert property (@(posedge clk_i) disable iff (rst_i)
        occ <= PTR_W'(FIQ_DEPTH));

endmodule

/* sim/fetch_checker.sv */
`timescale 1ns/1ns
// Fetch stage checker
// Tracks the expected next PC of each thread, checks every taken slot
// and reports per test and at the end
module fetch_checker #(
    parameter int          THREAD_NUM = 2,
    parameter logic [31:0] INST_KEY   = 32'h0
) (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic [THREAD_NUM-1:0][31:0]           rst_pc_i,
    input  logic [THREAD_NUM-1:0]                 br_mis_valid_i,
    input  logic [THREAD_NUM-1:0][31:0]           br_mis_target_i,
    input  fetch_pkg::dp_bundle_t                 dp_i,
    input  logic [fetch_pkg::DP_CNT_W-1:0]        dp_take_i,
    input  int                                    test_id_i,
    input  logic                                  test_end_i,
    input  logic                                  final_i,
    input  int                                    tb_err_i,     // Failures seen by the stimulus side
    output int                                    err_cnt_o,
    output logic [THREAD_NUM-1:0][31:0]           taken_o
);
    logic [THREAD_NUM-1:0][31:0] exp_pc;            // Next PC each thread must show
    logic [THREAD_NUM-1:0][31:0] taken = '0;
    int errs      = 0;
    int mark      = 0;                              // Error total at the last test end
    int slot_cnt  = 0;
    int n_pass    = 0;
    int n_fail    = 0;

    assign err_cnt_o = errs;
    assign taken_o   = taken;

    // Instruction memory content is the address XOR the key
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ INST_KEY;
    endfunction

    // ====================================================================
    // Slot compare
    // ====================================================================
    always @(posedge clk_i)
    begin : compare
        int          t;
        int          total;
        logic [31:0] pc;
        logic [31:0] inst;
        if (rst_i)
            exp_pc = rst_pc_i;                      // Streams restart at the reset PCs
        else
        begin
            t = int'(dp_i.thread);
            for (int n = 0; n < fetch_pkg::DP_NUM; n++)
            begin
                if (n < int'(dp_take_i))
                begin
                    pc   = dp_i.pc[n];
                    inst = dp_i.inst[n];
                    if (pc !== exp_pc[t])
                    begin
                        $display("MISMATCH dp_o.pc[%0d] thread %0d: got %h expected %h",
                                 n, t, pc, exp_pc[t]);
                        errs++;
                    end
                    if (inst !== mem_word(exp_pc[t]))
                    begin
                        $display("MISMATCH dp_o.inst[%0d] thread %0d: got %h expected %h",
                                 n, t, inst, mem_word(exp_pc[t]));
                        errs++;
                    end
                    exp_pc[t] = exp_pc[t] + 32'd4;
                    taken[t]  = taken[t] + 32'd1;
                    slot_cnt++;
                end
            end
            // Redirect after any takes of this cycle
            for (int i = 0; i < THREAD_NUM; i++)
                if (br_mis_valid_i[i])
                    exp_pc[i] = br_mis_target_i[i];
        end
        total = errs + tb_err_i;
        if (test_end_i)
        begin
            if (total == mark)
                n_pass++;
            else
                n_fail++;
            $display("test %0d: %s, %0d errors", test_id_i,
                     (total == mark) ? "passed" : "FAILED", total - mark);
            mark = total;
        end
        if (final_i)
            $display("summary: %0d tests, %0d passed, %0d failed, %0d slots checked, %0d errors",
                     n_pass + n_fail, n_pass, n_fail, slot_cnt, total);
    end

endmodule

/* sim/tb_top.sv */
`timescale 1ns/1ns
// Fetch stage testbench top
// Clock, reset, random stimulus and an in-order cache model with random latency
module tb_top;
    localparam int          THREAD_NUM = 2;
    localparam int          FIQ_DEPTH  = 8;
    localparam logic [31:0] INST_KEY   = 32'h5A3C_96E1;

    logic                        clk_i = 1'b0;
    logic                        rst_i;
    logic [1:0]                  thread_en;
    logic [1:0][31:0]            rst_pc;
    logic [1:0]                  br_mis;
    logic [1:0][31:0]            br_target;
    fetch_pkg::fetch_rsp_t       ic_rsp = '0;
    logic [1:0]                  dp_take;
    fetch_pkg::fetch_req_t       ic_req;
    fetch_pkg::dp_bundle_t       dp;

    logic [31:0]      rng_q     = 32'd70175;
    int               cyc       = 0;
    int               tb_errs   = 0;
    int               test_id   = 1;
    int               mis_cnt   = 0;
    int               chk_errs;
    logic [1:0]       last_avail;                   // Offer seen by the last drive
    logic             test_end  = 1'b0;
    logic             final_end = 1'b0;
    logic [1:0][31:0] taken;
    logic [1:0][31:0] base;
    int               n;
    logic [31:0]      q_addr[$];                    // Outstanding requests, oldest first
    logic             q_thr[$];
    int               q_due[$];

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ INST_KEY;
    endfunction

    // xorshift32 step on the shared state
    function automatic logic [31:0] next_rand();
        rng_q = rng_q ^ (rng_q << 13);
        rng_q = rng_q ^ (rng_q >> 17);
        rng_q = rng_q ^ (rng_q << 5);
        return rng_q;
    endfunction

    fetch_top #(
        .THREAD_NUM (THREAD_NUM),
        .FIQ_DEPTH  (FIQ_DEPTH)
    ) dut_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .thread_en_i     (thread_en),
        .rst_pc_i        (rst_pc),
        .br_mis_valid_i  (br_mis),
        .br_mis_target_i (br_target),
        .ic_rsp_i        (ic_rsp),
        .dp_take_i       (dp_take),
        .ic_req_o        (ic_req),
        .dp_o            (dp)
    );

    fetch_checker #(
        .THREAD_NUM (THREAD_NUM),
        .INST_KEY   (INST_KEY)
    ) u_chk (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .rst_pc_i        (rst_pc),
        .br_mis_valid_i  (br_mis),
        .br_mis_target_i (br_target),
        .dp_i            (dp),
        .dp_take_i       (dp_take),
        .test_id_i       (test_id),
        .test_end_i      (test_end),
        .final_i         (final_end),
        .tb_err_i        (tb_errs),
        .err_cnt_o       (chk_errs),
        .taken_o         (taken)
    );

    // ====================================================================
    // Cache model
    // ====================================================================
    always @(posedge clk_i)
    begin
        cyc = cyc + 1;
        if (rst_i)
        begin
            q_addr.delete();
            q_thr.delete();
            q_due.delete();
        end
        else if (ic_req.valid)
        begin
            q_addr.push_back(ic_req.addr);
            q_thr.push_back(ic_req.thread);
            q_due.push_back(cyc + int'(next_rand() % 6));   // 1 to 6 cycles
        end
    end

    // Answers in request order, one per cycle
    always @(negedge clk_i)
    begin
        ic_rsp = '0;
        if (q_addr.size() > 0 && cyc >= q_due[0])
        begin
            ic_rsp.valid  = 1'b1;
            ic_rsp.thread = q_thr.pop_front();
            ic_rsp.addr   = q_addr.pop_front();
            void'(q_due.pop_front());
            for (int s = 0; s < fetch_pkg::BLOCK_INSTS; s++)
                ic_rsp.data.slot[s] = mem_word(ic_rsp.addr + 32'(4 * s));
        end
    end

    // ====================================================================
    // Stimulus tasks
    // ====================================================================
    task automatic reset_dut(input logic [1:0] en, input logic [31:0] pc0,
                             input logic [31:0] pc1);
        @(negedge clk_i);
        rst_i     = 1'b1;
        thread_en = en;
        rst_pc[0] = pc0;
        rst_pc[1] = pc1;
        br_mis    = '0;
        dp_take   = '0;
        repeat (5) @(negedge clk_i);
        rst_i = 1'b0;
        @(posedge clk_i);                           // Values of the first cycle out of reset
        if (ic_req.valid !== 1'b0)
        begin
            $display("MISMATCH ic_req_o.valid after reset: got %h expected 0", ic_req.valid);
            tb_errs++;
        end
        if (dp.avail_num !== 2'd0)
        begin
            $display("MISMATCH dp_o.avail_num after reset: got %h expected 0", dp.avail_num);
            tb_errs++;
        end
    endtask

    // One cycle of random takes and optional mispredicts
    task automatic drive_cycle(input bit allow_mis, input bit allow_take);
        logic [31:0] r;
        @(negedge clk_i);
        r          = next_rand();
        last_avail = dp.avail_num;
        br_mis     = '0;
        dp_take    = '0;
        if (allow_mis && r[3:0] == 4'd0)
        begin
            br_mis[r[4]]    = 1'b1;                 // No take in a flush cycle
            br_target[r[4]] = 32'h4000_0000 + {16'h0, r[21:8], 2'b00};
            mis_cnt++;
        end
        else if (allow_take)
            dp_take = 2'(r[31:16] % (last_avail + 1));
    endtask

    task automatic run_until(input int min0, input int min1, input int min_mis,
                             input int limit);
        logic [1:0][31:0] start;
        int               mis0;
        int               k;
        start = taken;
        mis0  = mis_cnt;
        k     = 0;
        while ((taken[0] - start[0] < min0 || taken[1] - start[1] < min1 ||
                mis_cnt - mis0 < min_mis) && k < limit)
        begin
            drive_cycle(min_mis > 0, 1'b1);
            k++;
        end
        if (k >= limit)
        begin
            $display("Timeout: threads made too little progress in %0d cycles", limit);
            tb_errs++;
        end
    endtask

    task automatic finish_test();
        @(negedge clk_i);
        br_mis   = '0;
        dp_take  = '0;
        test_end = 1'b1;
        @(negedge clk_i);
        test_end = 1'b0;
        test_id++;
    endtask

    // ====================================================================
    // Test sequence
    // ====================================================================
    initial
    begin
        rst_i     = 1'b1;
        thread_en = '0;
        rst_pc    = '0;
        br_mis    = '0;
        br_target = '0;
        dp_take   = '0;

        reset_dut(2'b01, 32'h0000_1000, 32'h0000_2000);     // Test 1, outputs idle
        finish_test();

        reset_dut(2'b01, 32'h0000_1008, 32'h0000_2000);     // Mid-block start, thread 0 only
        base = taken;
        run_until(40, 0, 0, 2000);
        if (taken[1] != base[1])
        begin
            $display("Thread 1 dispatched instructions while disabled");
            tb_errs++;
        end
        finish_test();

        reset_dut(2'b11, 32'h1000_0004, 32'h2000_000C);     // Interleaved threads
        run_until(60, 60, 0, 3000);
        finish_test();

        reset_dut(2'b11, 32'h1000_0000, 32'h2000_0008);     // Random mispredicts
        run_until(40, 40, 8, 4000);
        finish_test();

        // Full queues, nothing taken while the fetch keeps going
        reset_dut(2'b11, 32'h1000_0004, 32'h2000_0008);
        repeat (80) drive_cycle(1'b0, 1'b0);
        thread_en = '0;
        n = 0;
        while (q_addr.size() != 0 && n < 50)
        begin
            drive_cycle(1'b0, 1'b0);
            n++;
        end
        if (n >= 50)
        begin
            $display("Timeout: cache responses did not drain");
            tb_errs++;
        end
        base = taken;
        n    = 0;
        do
        begin
            drive_cycle(1'b0, 1'b1);
            n++;
        end
        while (last_avail != 2'd0 && n < 200);
        if (n >= 200)
        begin
            $display("Timeout: queues did not empty after taking resumed");
            tb_errs++;
        end
        for (int t = 0; t < 2; t++)
        begin
            if (taken[t] - base[t] != 32'(FIQ_DEPTH))
            begin
                $display("Thread %0d held %0d instructions, a full queue holds %0d",
                         t, taken[t] - base[t], FIQ_DEPTH);
                tb_errs++;
            end
        end
        thread_en = 2'b11;                          // Stream must pick up without a gap
        run_until(30, 30, 0, 3000);
        finish_test();

        @(negedge clk_i);
        final_end = 1'b1;
        @(negedge clk_i);
        final_end = 1'b0;
        if (chk_errs + tb_errs == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule
